/* build.f */
decoder_pkg.sv
link_pkg.sv
neighbor_link.sv
processing_unit.sv
stage_controller.sv
uf_decoder_top.sv
uf_decoder_chk.sv
uf_decoder_tb.sv

/* decoder_pkg.sv */
package decoder_pkg;

    // Array size of the ancilla chain.
    localparam int num_units = 4;
    localparam int unit_id_width = 2;    // Enough bits for a root index.

    localparam int stage_width = 3;

    // Growth a link needs before it joins its two units.
    localparam int growth_width = 2;
    localparam logic [growth_width-1:0] link_weight = 2'd2;

    typedef enum logic [stage_width-1:0] {
        STAGE_IDLE    = 3'd0,    // Waiting for a syndrome.
        STAGE_LOADING = 3'd1,    // Units latch their defect bits.
        STAGE_GROW    = 3'd2,
        STAGE_MERGE   = 3'd3,    // Repeats until no unit changes.
        STAGE_PARITY  = 3'd4,
        STAGE_RESULT  = 3'd5     // Result handshake in progress.
    } stage_t;

    // Roots are listed for units 0 to 3, unit 0 in the low bits.
    typedef struct packed {
        logic [num_units-1:0][unit_id_width-1:0] roots;
        logic [num_units-1:0]                    touching;
    } decode_result_t;

endpackage

/* link_pkg.sv */
package link_pkg;

    // What one unit shows to one side of a link.
    typedef struct packed {
        logic [decoder_pkg::unit_id_width-1:0] root;
        logic                                  increase;    // Growth request in GROW.
        logic                                  touching;
    } link_side_t;

    // A boundary link has a unit on side a only.
    typedef enum logic {
        LINK_INTERNAL = 1'b0,
        LINK_BOUNDARY = 1'b1
    } link_kind_t;

endpackage

/* neighbor_link.sv */
`timescale 1ns/1ps

module neighbor_link #(
    parameter link_pkg::link_kind_t kind = link_pkg::LINK_INTERNAL
) (
    input  logic                  clk,
    input  logic                  reset,
    input  decoder_pkg::stage_t   stage,
    input  link_pkg::link_side_t  a_side,
    input  link_pkg::link_side_t  b_side,
    output link_pkg::link_side_t  a_view,
    output link_pkg::link_side_t  b_view,
    output logic                  fully_grown
);

    logic [decoder_pkg::growth_width-1:0] growth;
    logic [decoder_pkg::growth_width:0]   increase_sum;
    logic [decoder_pkg::growth_width:0]   growth_sum;

    generate
        if (kind == link_pkg::LINK_BOUNDARY) begin : gen_boundary
            // Only the unit on side a can grow toward the boundary.
            assign increase_sum = {{decoder_pkg::growth_width{1'b0}}, a_side.increase};

            // The boundary looks like a neighbor in the unit's own cluster.
            assign a_view = '{
                root:     a_side.root,
                increase: 1'b0,
                touching: fully_grown
            };
            assign b_view = a_side;
        end else begin : gen_internal
            assign increase_sum = {{decoder_pkg::growth_width{1'b0}}, a_side.increase}
                                + {{decoder_pkg::growth_width{1'b0}}, b_side.increase};

            assign a_view = b_side;    // Each unit sees the other end.
            assign b_view = a_side;
        end
    endgenerate

    assign growth_sum = {1'b0, growth} + increase_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else begin
            case (stage)
                decoder_pkg::STAGE_LOADING: begin
                    growth <= '0;
                end
                decoder_pkg::STAGE_GROW: begin
                    // Saturate so a grown link stays grown.
                    if (growth_sum >= {1'b0, decoder_pkg::link_weight}) begin
                        growth <= decoder_pkg::link_weight;
                    end else begin
                        growth <= growth_sum[decoder_pkg::growth_width-1:0];
                    end
                end
                default: begin
                    growth <= growth;
                end
            endcase
        end
    end

    assign fully_grown = (growth >= decoder_pkg::link_weight);

endmodule

/* processing_unit.sv */
`timescale 1ns/1ps

module processing_unit #(
    parameter int unit_index = 0
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  decoder_pkg::stage_t                   stage,
    input  logic                                  defect,
    input  logic [decoder_pkg::num_units-1:0]     cluster_odd,
    input  link_pkg::link_side_t                  left_view,
    input  link_pkg::link_side_t                  right_view,
    input  logic                                  left_grown,
    input  logic                                  right_grown,
    output link_pkg::link_side_t                  left_side,
    output link_pkg::link_side_t                  right_side,
    output logic [decoder_pkg::unit_id_width-1:0] root,
    output logic                                  touching,
    output logic                                  odd_defect,
    output logic                                  changed
);

    localparam logic [decoder_pkg::unit_id_width-1:0] own_id =
        unit_index[decoder_pkg::unit_id_width-1:0];

    logic                                  active;
    logic                                  grow_req;
    logic [decoder_pkg::unit_id_width-1:0] merge_root;
    logic                                  merge_touching;

    // An odd cluster keeps growing until it reaches a boundary.
    assign active   = cluster_odd[root] && !touching;
    assign grow_req = (stage == decoder_pkg::STAGE_GROW) && active;

    always_comb begin
        merge_root     = root;
        merge_touching = touching;
        if (left_grown) begin
            if (left_view.root < merge_root) begin
                merge_root = left_view.root;
            end
            merge_touching = merge_touching | left_view.touching;
        end
        if (right_grown) begin
            if (right_view.root < merge_root) begin
                merge_root = right_view.root;
            end
            merge_touching = merge_touching | right_view.touching;
        end
    end

    // One hop per MERGE cycle, so the controller repeats MERGE while this is set.
    assign changed = (stage == decoder_pkg::STAGE_MERGE)
                   && ((merge_root != root) || (merge_touching != touching));

    always_ff @(posedge clk) begin
        if (reset) begin
            root       <= own_id;
            touching   <= 1'b0;
            odd_defect <= 1'b0;
        end else begin
            case (stage)
                decoder_pkg::STAGE_LOADING: begin
                    root       <= own_id;    // Every unit starts as its own cluster.
                    touching   <= 1'b0;
                    odd_defect <= defect;
                end
                decoder_pkg::STAGE_MERGE: begin
                    root     <= merge_root;
                    touching <= merge_touching;
                end
                default: begin
                    root     <= root;
                    touching <= touching;
                end
            endcase
        end
    end

    assign left_side = '{
        root:     root,
        increase: grow_req,
        touching: touching
    };

    assign right_side = '{
        root:     root,
        increase: grow_req,
        touching: touching
    };

endmodule

/* stage_controller.sv */
`timescale 1ns/1ps

module stage_controller (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  logic [decoder_pkg::num_units-1:0]                             syndrome,
    input  logic                                                          load_req,
    output logic                                                          load_ack,
    output logic                                                          res_req,
    input  logic                                                          res_ack,
    output decoder_pkg::decode_result_t                                   result,
    output decoder_pkg::stage_t                                           stage,
    output logic [decoder_pkg::num_units-1:0]                             unit_defect,
    input  logic [decoder_pkg::num_units-1:0][decoder_pkg::unit_id_width-1:0] roots,
    input  logic [decoder_pkg::num_units-1:0]                             touching,
    input  logic [decoder_pkg::num_units-1:0]                             defects,
    input  logic [decoder_pkg::num_units-1:0]                             changed,
    output logic [decoder_pkg::num_units-1:0]                             cluster_odd
);

    logic                                 res_done;    // res_ack seen for this result.
    logic [decoder_pkg::num_units-1:0]    parity_next;
    logic                                 any_active;

    // Defect parity per cluster, indexed by root id.
    always_comb begin
        parity_next = '0;
        for (int u = 0; u < decoder_pkg::num_units; u++) begin
            if (defects[u]) begin
                parity_next[roots[u]] = ~parity_next[roots[u]];
            end
        end
    end

    always_comb begin
        any_active = 1'b0;
        for (int u = 0; u < decoder_pkg::num_units; u++) begin
            if (parity_next[roots[u]] && !touching[u]) begin
                any_active = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage       <= decoder_pkg::STAGE_IDLE;
            load_ack    <= 1'b0;
            res_req     <= 1'b0;
            res_done    <= 1'b0;
            cluster_odd <= '0;
        end else begin
            if (load_ack && !load_req) begin
                load_ack <= 1'b0;
            end
            case (stage)
                decoder_pkg::STAGE_IDLE: begin
                    if (load_req && !load_ack) begin
                        load_ack <= 1'b1;
                        stage    <= decoder_pkg::STAGE_LOADING;
                    end
                end
                decoder_pkg::STAGE_LOADING: begin
                    stage <= decoder_pkg::STAGE_PARITY;
                end
                decoder_pkg::STAGE_PARITY: begin
                    cluster_odd <= parity_next;
                    stage <= any_active ? decoder_pkg::STAGE_GROW : decoder_pkg::STAGE_RESULT;
                end
                decoder_pkg::STAGE_GROW: begin
                    stage <= decoder_pkg::STAGE_MERGE;
                end
                decoder_pkg::STAGE_MERGE: begin
                    if (!(|changed)) begin
                        stage <= decoder_pkg::STAGE_PARITY;
                    end
                end
                decoder_pkg::STAGE_RESULT: begin
                    if (!res_req && !res_done) begin
                        res_req <= 1'b1;
                    end else if (res_req && res_ack) begin
                        res_req  <= 1'b0;
                        res_done <= 1'b1;
                    end else if (res_done && !res_ack && !load_req) begin
                        res_done <= 1'b0;
                        stage    <= decoder_pkg::STAGE_IDLE;
                    end
                end
                default: begin
                    stage <= decoder_pkg::STAGE_IDLE;
                end
            endcase
        end
    end

    // Syndrome is only valid until load_ack rises, so it is captured here.
    always_ff @(posedge clk) begin
        if ((stage == decoder_pkg::STAGE_IDLE) && load_req && !load_ack) begin
            unit_defect <= syndrome;
        end
        if ((stage == decoder_pkg::STAGE_PARITY) && !any_active) begin
            result.roots    <= roots;
            result.touching <= touching;
        end
    end

endmodule

/* uf_decoder_chk.sv */
`timescale 1ns/1ps

module uf_decoder_chk (
    input logic                        clk,
    input logic                        reset,
    input logic                        load_req,
    input logic                        load_ack,
    input logic                        res_req,
    input logic                        res_ack,
    input decoder_pkg::decode_result_t result,
    input decoder_pkg::stage_t         stage
);

    int failure_count = 0;

    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        $rose(load_ack) |-> $past(load_req))
        else begin
            $error("load_ack rose without load_req");
            failure_count++;
        end

    // Four-phase rule on the result side.
    req_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        (res_req && !res_ack) |=> res_req)
        else begin
            $error("res_req fell before res_ack");
            failure_count++;
        end

    result_stable: assert property (@(posedge clk) disable iff (reset)
        (res_req && $past(res_req)) |-> $stable(result))
        else begin
            $error("result changed while res_req was high");
            failure_count++;
        end

    req_only_in_result: assert property (@(posedge clk) disable iff (reset)
        res_req |-> (stage == decoder_pkg::STAGE_RESULT))
        else begin
            $error("res_req high outside the result stage");
            failure_count++;
        end

    // A new syndrome is taken only from IDLE, after the last result handshake.
    load_only_when_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(load_ack) |-> ($past(stage) == decoder_pkg::STAGE_IDLE))
        else begin
            $error("load_ack rose outside the idle stage");
            failure_count++;
        end

endmodule

bind stage_controller uf_decoder_chk chk0 (
    .clk      (clk),
    .reset    (reset),
    .load_req (load_req),
    .load_ack (load_ack),
    .res_req  (res_req),
    .res_ack  (res_ack),
    .result   (result),
    .stage    (stage)
);

/* uf_decoder_tb.sv */
`timescale 1ns/1ps

module uf_decoder_tb;

    localparam int timeout_cycles = 200;

    typedef struct packed {
        logic                              reset_first;    // Abort a decode with reset first.
        logic                              stall;          // Hold res_ack low for a while.
        logic [decoder_pkg::num_units-1:0] syndrome;
        decoder_pkg::decode_result_t       expected;
    } test_vector_t;

    logic                              clk;
    logic                              reset;
    logic [decoder_pkg::num_units-1:0] syndrome;
    logic                              load_req;
    logic                              load_ack;
    logic                              res_req;
    logic                              res_ack;
    decoder_pkg::decode_result_t       result;

    test_vector_t vectors [6];
    logic [31:0]  lfsr_state;

    uf_decoder_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .syndrome (syndrome),
        .load_req (load_req),
        .load_ack (load_ack),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .result   (result)
    );

    always #5 clk = ~clk;

    // The bound protocol checker counts its own failures.
    always @(negedge clk) begin
        if (dut0.u_ctrl.chk0.failure_count != 0) begin
            $display("Regression failed");
            $fatal(1, "a handshake or stage assertion failed");
        end
    end

    function automatic test_vector_t make_entry(input logic reset_first, input logic stall,
                                                input logic [3:0] vec,
                                                input logic [1:0] r0, input logic [1:0] r1,
                                                input logic [1:0] r2, input logic [1:0] r3,
                                                input logic [3:0] touch);
        test_vector_t entry;
        entry.reset_first         = reset_first;
        entry.stall               = stall;
        entry.syndrome            = vec;
        entry.expected.roots[0]   = r0;    // Unit 0 sits in the low bits.
        entry.expected.roots[1]   = r1;
        entry.expected.roots[2]   = r2;
        entry.expected.roots[3]   = r3;
        entry.expected.touching   = touch;
        return entry;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "%s does not hold the expected value", name);
        end
    endtask

    task automatic wait_load_ack(input logic level);
        int cycles;
        cycles = 0;
        while (load_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Regression failed");
                $fatal(1, "load_ack never went to %0b", level);
            end
        end
    endtask

    task automatic wait_res_req(input logic level);
        int cycles;
        cycles = 0;
        while (res_req !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Regression failed");
                $fatal(1, "res_req never went to %0b", level);
            end
        end
    endtask

    task automatic load_syndrome(input logic [3:0] vec);
        @(negedge clk);
        syndrome = vec;
        load_req = 1'b1;
        wait_load_ack(1'b1);
        @(negedge clk);
        load_req = 1'b0;
        wait_load_ack(1'b0);
    endtask

    task automatic read_result(input int hold_cycles, input decoder_pkg::decode_result_t exp);
        wait_res_req(1'b1);
        check_value("result", 32'(result), 32'(exp));
        for (int c = 0; c < hold_cycles; c++) begin
            @(negedge clk);
            check_value("res_req", 32'(res_req), 32'd1);
            check_value("result", 32'(result), 32'(exp));
        end
        @(negedge clk);
        res_ack = 1'b1;
        wait_res_req(1'b0);
        @(negedge clk);
        res_ack = 1'b0;
    endtask

    task automatic abort_decode(input logic [3:0] vec);
        load_syndrome(vec);
        repeat (3) @(negedge clk);
        reset = 1'b1;
        repeat (10) @(negedge clk);    // Long enough that an unreset decode would finish.
        check_value("load_ack", 32'(load_ack), 32'd0);
        check_value("res_req", 32'(res_req), 32'd0);
        reset = 1'b0;
    endtask

    initial begin
        int hold;
        clk        = 1'b0;
        reset      = 1'b1;
        syndrome   = '0;
        load_req   = 1'b0;
        res_ack    = 1'b0;
        lfsr_state = 32'h48528204;

        // Syndrome bit u is unit u, and roots are listed for units 0 to 3.
        vectors[0] = make_entry(1'b0, 1'b0, 4'b0000, 2'd0, 2'd1, 2'd2, 2'd3, 4'b0000);
        vectors[1] = make_entry(1'b0, 1'b1, 4'b0110, 2'd0, 2'd1, 2'd1, 2'd3, 4'b0000);
        vectors[2] = make_entry(1'b0, 1'b0, 4'b0001, 2'd0, 2'd0, 2'd2, 2'd3, 4'b0011);
        // Units 1 and 2 both grow the middle link, so the two pairs join.
        vectors[3] = make_entry(1'b0, 1'b1, 4'b1111, 2'd0, 2'd0, 2'd0, 2'd0, 4'b0000);
        vectors[4] = make_entry(1'b1, 1'b0, 4'b1000, 2'd0, 2'd1, 2'd2, 2'd2, 4'b1100);
        vectors[5] = make_entry(1'b0, 1'b1, 4'b0011, 2'd0, 2'd0, 2'd2, 2'd3, 4'b0000);

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 6; i++) begin
            if (vectors[i].reset_first) begin
                abort_decode(4'b1111);
            end
            hold = 0;
            if (vectors[i].stall) begin
                draw_bits(4, hold);
                hold = hold + 1;
            end
            load_syndrome(vectors[i].syndrome);
            read_result(hold, vectors[i].expected);
        end

        repeat (2) @(negedge clk);
        if (dut0.u_ctrl.chk0.failure_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "a handshake or stage assertion failed");
        end
    end

endmodule

/* uf_decoder_top.sv */
`timescale 1ns/1ps

module uf_decoder_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [decoder_pkg::num_units-1:0] syndrome,
    input  logic                              load_req,
    output logic                              load_ack,
    output logic                              res_req,
    input  logic                              res_ack,
    output decoder_pkg::decode_result_t       result
);

    decoder_pkg::stage_t                                              stage;
    logic [decoder_pkg::num_units-1:0]                                unit_defect;
    logic [decoder_pkg::num_units-1:0]                                cluster_odd;
    logic [decoder_pkg::num_units-1:0][decoder_pkg::unit_id_width-1:0] roots;
    logic [decoder_pkg::num_units-1:0]                                touching;
    logic [decoder_pkg::num_units-1:0]                                defects;
    logic [decoder_pkg::num_units-1:0]                                changed;

    link_pkg::link_side_t [decoder_pkg::num_units-1:0] left_side;
    link_pkg::link_side_t [decoder_pkg::num_units-1:0] right_side;
    link_pkg::link_side_t [decoder_pkg::num_units-1:0] left_view;
    link_pkg::link_side_t [decoder_pkg::num_units-1:0] right_view;

    // Link k sits left of unit k, link num_units right of the last unit.
    logic [decoder_pkg::num_units:0] link_grown;

    stage_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .syndrome    (syndrome),
        .load_req    (load_req),
        .load_ack    (load_ack),
        .res_req     (res_req),
        .res_ack     (res_ack),
        .result      (result),
        .stage       (stage),
        .unit_defect (unit_defect),
        .roots       (roots),
        .touching    (touching),
        .defects     (defects),
        .changed     (changed),
        .cluster_odd (cluster_odd)
    );

    for (genvar i = 0; i < decoder_pkg::num_units; i++) begin : gen_unit
        processing_unit #(.unit_index(i)) u_unit (
            .clk         (clk),
            .reset       (reset),
            .stage       (stage),
            .defect      (unit_defect[i]),
            .cluster_odd (cluster_odd),
            .left_view   (left_view[i]),
            .right_view  (right_view[i]),
            .left_grown  (link_grown[i]),
            .right_grown (link_grown[i+1]),
            .left_side   (left_side[i]),
            .right_side  (right_side[i]),
            .root        (roots[i]),
            .touching    (touching[i]),
            .odd_defect  (defects[i]),
            .changed     (changed[i])
        );
    end

    neighbor_link #(.kind(link_pkg::LINK_BOUNDARY)) u_link_left (
        .clk         (clk),
        .reset       (reset),
        .stage       (stage),
        .a_side      (left_side[0]),
        .b_side      ('0),
        .a_view      (left_view[0]),
        .b_view      (),
        .fully_grown (link_grown[0])
    );

    for (genvar k = 1; k < decoder_pkg::num_units; k++) begin : gen_link
        neighbor_link #(.kind(link_pkg::LINK_INTERNAL)) u_link (
            .clk         (clk),
            .reset       (reset),
            .stage       (stage),
            .a_side      (right_side[k-1]),
            .b_side      (left_side[k]),
            .a_view      (right_view[k-1]),
            .b_view      (left_view[k]),
            .fully_grown (link_grown[k])
        );
    end

    neighbor_link #(.kind(link_pkg::LINK_BOUNDARY)) u_link_right (
        .clk         (clk),
        .reset       (reset),
        .stage       (stage),
        .a_side      (right_side[decoder_pkg::num_units-1]),
        .b_side      ('0),
        .a_view      (right_view[decoder_pkg::num_units-1]),
        .b_view      (),
        .fully_grown (link_grown[decoder_pkg::num_units])
    );

endmodule
